// ==== hw/rom_sdram_pkg.sv ====
// SDRAM widths, bank and command enums, ROM region offsets
`default_nettype none

package rom_sdram_pkg;

    // SDRAM word address and read data widths
    localparam int SDRAM_AW = 22;
    localparam int SDRAM_DW = 32;

    // Bank field of the SDRAM address
    typedef enum logic [1:0] {
        BANK_MAIN      = 2'd0,
        BANK_SOUND     = 2'd1,
        BANK_CHAR_SCR1 = 2'd2,
        BANK_SCR2_OBJ  = 2'd3
    } bank_t;

    // Commands toward the SDRAM read port
    typedef enum logic [1:0] {
        CMD_NOP     = 2'd0,
        CMD_READ    = 2'd1,
        CMD_REFRESH = 2'd2
    } sdram_cmd_t;

    // Second region of a shared bank starts at the 1M word boundary
    localparam logic [SDRAM_AW-1:0] ZERO_OFFSET = '0;
    localparam logic [SDRAM_AW-1:0] SCR1_OFFSET = 22'h10_0000;
    localparam logic [SDRAM_AW-1:0] OBJ_OFFSET  = 22'h10_0000;

endpackage

`default_nettype wire

// ==== hw/rom_slot.sv ====
// ROM client slot with last-word cache, hit check, lane select and fetch request
`timescale 1ns/1ps
`default_nettype none

module rom_slot #(
    parameter int AW = 17,
    parameter int DW = 16,
    parameter logic [rom_sdram_pkg::SDRAM_AW-1:0] OFFSET = '0
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cs,
    input  logic [AW-1:0]                      addr,
    output logic                               ok,
    output logic [DW-1:0]                      dout,
    output logic                               slot_req,
    output logic [rom_sdram_pkg::SDRAM_AW-1:0] slot_addr,
    input  logic                               slot_ack,
    input  logic                               slot_fill,
    input  logic [rom_sdram_pkg::SDRAM_DW-1:0] fill_data
);
    import rom_sdram_pkg::*;

    // Lane bits: 1 for 16-bit clients, 2 for byte clients
    localparam int LB = $clog2(SDRAM_DW / DW);
    localparam int TW = AW - LB;

    logic                valid;
    logic                pend;
    logic [TW-1:0]       tag_q;
    logic [TW-1:0]       req_tag;
    logic [SDRAM_DW-1:0] data_q;
    logic [TW-1:0]       cur_tag;
    logic [LB-1:0]       lane;
    logic                hit;
    logic                start;

    assign cur_tag = addr[AW-1:LB];
    assign lane    = addr[LB-1:0];
    assign hit     = valid && (tag_q == cur_tag);

    // Combinational compare, so ok falls with the address change
    assign ok   = hit;
    assign dout = data_q[lane*DW +: DW];

    // New fetch only when nothing is in flight for this slot
    assign start     = cs && !hit && !slot_req && !pend;
    assign slot_addr = OFFSET + SDRAM_AW'(req_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid    <= 1'b0;
            pend     <= 1'b0;
            slot_req <= 1'b0;
        end else begin
            if (slot_req && slot_ack) begin
                slot_req <= 1'b0;
                pend     <= 1'b1;
            end else if (start) begin
                slot_req <= 1'b1;
            end
            if (slot_fill) begin
                pend  <= 1'b0;
                valid <= 1'b1;
            end
        end
    end

    // Requested tag and cached word
    always_ff @(posedge clk) begin
        if (start) begin
            req_tag <= cur_tag;
        end
        if (slot_fill) begin
            tag_q  <= req_tag;
            data_q <= fill_data;
        end
    end

    // The bank port samples slot_addr any time before the ack
    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        slot_req && !slot_ack |=> $stable(slot_addr));

endmodule

`default_nettype wire

// ==== hw/rom_bank_port.sv ====
// Bank port with one or two ROM slots, slot arbitration and bank request
`timescale 1ns/1ps
`default_nettype none

module rom_bank_port #(
    parameter bit SLOT1_EN = 1'b0,
    parameter int AW0 = 17,
    parameter int DW0 = 16,
    parameter logic [rom_sdram_pkg::SDRAM_AW-1:0] OFFSET0 = '0,
    parameter int AW1 = 17,
    parameter int DW1 = 16,
    parameter logic [rom_sdram_pkg::SDRAM_AW-1:0] OFFSET1 = '0
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               slot0_cs,
    input  logic [AW0-1:0]                     slot0_addr,
    output logic                               slot0_ok,
    output logic [DW0-1:0]                     slot0_dout,
    input  logic                               slot1_cs,
    input  logic [AW1-1:0]                     slot1_addr,
    output logic                               slot1_ok,
    output logic [DW1-1:0]                     slot1_dout,
    output logic                               bank_req,
    output logic [rom_sdram_pkg::SDRAM_AW-1:0] bank_addr,
    input  logic                               bank_ack,
    input  logic                               bank_rdy,
    input  logic [rom_sdram_pkg::SDRAM_DW-1:0] data_read
);
    import rom_sdram_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_DATA
    } state_t;

    state_t              state;
    logic                owner;
    logic                s0_req;
    logic                s1_req;
    logic [SDRAM_AW-1:0] s0_addr;
    logic [SDRAM_AW-1:0] s1_addr;
    logic                s0_ack;
    logic                s1_ack;
    logic                s0_fill;
    logic                s1_fill;

    assign bank_req = (state == WAIT_ACK);

    // Ack and fill go only to the slot that owns the read
    assign s0_ack  = bank_ack && (state == WAIT_ACK) && !owner;
    assign s1_ack  = bank_ack && (state == WAIT_ACK) && owner;
    assign s0_fill = bank_rdy && (state == WAIT_DATA) && !owner;
    assign s1_fill = bank_rdy && (state == WAIT_DATA) && owner;

    rom_slot #(
        .AW     ( AW0     ),
        .DW     ( DW0     ),
        .OFFSET ( OFFSET0 )
    ) u_slot0 (
        .clk       ( clk        ),
        .rst       ( rst        ),
        .cs        ( slot0_cs   ),
        .addr      ( slot0_addr ),
        .ok        ( slot0_ok   ),
        .dout      ( slot0_dout ),
        .slot_req  ( s0_req     ),
        .slot_addr ( s0_addr    ),
        .slot_ack  ( s0_ack     ),
        .slot_fill ( s0_fill    ),
        .fill_data ( data_read  )
    );

    generate
        if (SLOT1_EN) begin : g_slot1
            rom_slot #(
                .AW     ( AW1     ),
                .DW     ( DW1     ),
                .OFFSET ( OFFSET1 )
            ) u_slot1 (
                .clk       ( clk        ),
                .rst       ( rst        ),
                .cs        ( slot1_cs   ),
                .addr      ( slot1_addr ),
                .ok        ( slot1_ok   ),
                .dout      ( slot1_dout ),
                .slot_req  ( s1_req     ),
                .slot_addr ( s1_addr    ),
                .slot_ack  ( s1_ack     ),
                .slot_fill ( s1_fill    ),
                .fill_data ( data_read  )
            );
        end else begin : g_no_slot1
            assign slot1_ok   = 1'b0;
            assign slot1_dout = '0;
            assign s1_req     = 1'b0;
            assign s1_addr    = '0;
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            owner <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // Slot 0 first
                    if (s0_req) begin
                        owner <= 1'b0;
                        state <= WAIT_ACK;
                    end else if (s1_req) begin
                        owner <= 1'b1;
                        state <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (bank_ack) begin
                        state <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (bank_rdy) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            bank_addr <= s0_req ? s0_addr : s1_addr;
        end
    end

    // The scheduler returns data only to a bank that has a read open
    a_rdy_open: assert property (@(posedge clk) disable iff (rst)
        bank_rdy |-> state != IDLE);

endmodule

`default_nettype wire

// ==== hw/sdram_bank_sched.sv ====
// Round-robin scheduler of four bank reads onto one SDRAM read port, with refresh
`timescale 1ns/1ps
`default_nettype none

module sdram_bank_sched (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               refresh_en,
    input  logic [3:0]                         bank_req,
    input  logic [rom_sdram_pkg::SDRAM_AW-1:0] bank_addr0,
    input  logic [rom_sdram_pkg::SDRAM_AW-1:0] bank_addr1,
    input  logic [rom_sdram_pkg::SDRAM_AW-1:0] bank_addr2,
    input  logic [rom_sdram_pkg::SDRAM_AW-1:0] bank_addr3,
    output logic [3:0]                         bank_ack,
    output logic [3:0]                         bank_rdy,
    output logic [rom_sdram_pkg::SDRAM_DW-1:0] data_read,
    output rom_sdram_pkg::sdram_cmd_t          sdram_cmd,
    output rom_sdram_pkg::bank_t               sdram_bank,
    output logic [rom_sdram_pkg::SDRAM_AW-1:0] sdram_addr,
    input  logic                               sdram_ack,
    input  logic                               sdram_rdy,
    input  logic [rom_sdram_pkg::SDRAM_DW-1:0] sdram_data
);
    import rom_sdram_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_DATA
    } state_t;

    state_t              state;
    logic [1:0]          grant;
    logic [SDRAM_AW-1:0] addr_mux [4];

    assign addr_mux[0] = bank_addr0;
    assign addr_mux[1] = bank_addr1;
    assign addr_mux[2] = bank_addr2;
    assign addr_mux[3] = bank_addr3;

    // Read data is shared, bank_rdy tells whose it is
    assign data_read = sdram_data;

    // Search starts at the bank after the one served last
    always_comb begin : pick
        logic [1:0] idx;
        logic       found;
        grant = 2'(sdram_bank);
        found = 1'b0;
        idx   = '0;
        for (int i = 1; i <= 4; i++) begin
            idx = 2'(sdram_bank) + 2'(i);
            if (!found && bank_req[idx]) begin
                grant = idx;
                found = 1'b1;
            end
        end
    end

    always_comb begin
        bank_ack = '0;
        bank_rdy = '0;
        if (state == ISSUE && sdram_cmd == CMD_READ && sdram_ack) begin
            bank_ack[sdram_bank] = 1'b1;
        end
        if (state == WAIT_DATA && sdram_rdy) begin
            bank_rdy[sdram_bank] = 1'b1;
        end
    end

    // sdram_bank doubles as the round-robin pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            sdram_cmd  <= CMD_NOP;
            sdram_bank <= BANK_SCR2_OBJ;
        end else begin
            case (state)
                IDLE: begin
                    if (|bank_req) begin
                        sdram_cmd  <= CMD_READ;
                        sdram_bank <= bank_t'(grant);
                        state      <= ISSUE;
                    end else if (refresh_en) begin
                        sdram_cmd <= CMD_REFRESH;
                        state     <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (sdram_ack) begin
                        sdram_cmd <= CMD_NOP;
                        state     <= (sdram_cmd == CMD_READ) ? WAIT_DATA : IDLE;
                    end
                end
                WAIT_DATA: begin
                    if (sdram_rdy) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            sdram_addr <= addr_mux[grant];
        end
    end

    // One ack at a time, and only to a bank that still holds its request
    a_ack_owner: assert property (@(posedge clk) disable iff (rst)
        $onehot0(bank_ack) && (bank_ack & ~bank_req) == 4'b0);

    // Command held by the SDRAM port until it takes it
    a_cmd_hold: assert property (@(posedge clk) disable iff (rst)
        sdram_cmd != CMD_NOP && !sdram_ack |=> $stable(sdram_cmd) && $stable(sdram_addr));

endmodule

`default_nettype wire

// ==== hw/game_sdram.sv ====
// ROM fetch top: six client slots on four bank ports and the SDRAM scheduler
`timescale 1ns/1ps
`default_nettype none

module game_sdram #(
    parameter int MAIN_AW = 17,
    parameter int SND_AW  = 15,
    parameter int CHAR_AW = 13,
    parameter int SCR1_AW = 17,
    parameter int SCR2_AW = 15,
    parameter int OBJ_AW  = 17
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               LVBL,
    input  logic                               main_cs,
    input  logic                               snd_cs,
    output logic                               main_ok,
    output logic                               snd_ok,
    output logic                               char_ok,
    output logic                               scr1_ok,
    output logic                               scr2_ok,
    output logic                               obj_ok,
    input  logic [MAIN_AW-1:0]                 main_addr,
    input  logic [SND_AW-1:0]                  snd_addr,
    input  logic [CHAR_AW-1:0]                 char_addr,
    input  logic [SCR1_AW-1:0]                 scr1_addr,
    input  logic [SCR2_AW-1:0]                 scr2_addr,
    input  logic [OBJ_AW-1:0]                  obj_addr,
    output logic [15:0]                        main_data,
    output logic [7:0]                         snd_data,
    output logic [15:0]                        char_data,
    output logic [15:0]                        scr1_data,
    output logic [15:0]                        scr2_data,
    output logic [15:0]                        obj_data,
    // SDRAM read port
    output rom_sdram_pkg::sdram_cmd_t          sdram_cmd,
    output rom_sdram_pkg::bank_t               sdram_bank,
    output logic [rom_sdram_pkg::SDRAM_AW-1:0] sdram_addr,
    input  logic                               sdram_ack,
    input  logic                               sdram_rdy,
    input  logic [rom_sdram_pkg::SDRAM_DW-1:0] sdram_data,
    output logic                               refresh_en
);
    import rom_sdram_pkg::*;

    logic [3:0]          bank_req;
    logic [3:0]          bank_ack;
    logic [3:0]          bank_rdy;
    logic [SDRAM_AW-1:0] bank_addr [4];
    logic [SDRAM_DW-1:0] data_read;

    // Refresh only in vertical blank
    assign refresh_en = ~LVBL;

    // Bank 0: main CPU
    rom_bank_port #(
        .AW0 ( MAIN_AW ), .DW0 ( 16 ), .OFFSET0 ( ZERO_OFFSET )
    ) u_bank0 (
        .clk ( clk ), .rst ( rst ),
        .slot0_cs ( main_cs ), .slot0_addr ( main_addr ),
        .slot0_ok ( main_ok ), .slot0_dout ( main_data ),
        .slot1_cs ( 1'b0 ), .slot1_addr ( '0 ), .slot1_ok ( ), .slot1_dout ( ),
        .bank_req ( bank_req[0] ), .bank_addr ( bank_addr[0] ),
        .bank_ack ( bank_ack[0] ), .bank_rdy ( bank_rdy[0] ), .data_read ( data_read )
    );

    // Bank 1: sound CPU, byte wide
    rom_bank_port #(
        .AW0 ( SND_AW ), .DW0 ( 8 ), .OFFSET0 ( ZERO_OFFSET )
    ) u_bank1 (
        .clk ( clk ), .rst ( rst ),
        .slot0_cs ( snd_cs ), .slot0_addr ( snd_addr ),
        .slot0_ok ( snd_ok ), .slot0_dout ( snd_data ),
        .slot1_cs ( 1'b0 ), .slot1_addr ( '0 ), .slot1_ok ( ), .slot1_dout ( ),
        .bank_req ( bank_req[1] ), .bank_addr ( bank_addr[1] ),
        .bank_ack ( bank_ack[1] ), .bank_rdy ( bank_rdy[1] ), .data_read ( data_read )
    );

    // Bank 2: char and scroll 1, fetched only while the line is visible
    rom_bank_port #(
        .SLOT1_EN ( 1'b1 ),
        .AW0 ( CHAR_AW ), .DW0 ( 16 ), .OFFSET0 ( ZERO_OFFSET ),
        .AW1 ( SCR1_AW ), .DW1 ( 16 ), .OFFSET1 ( SCR1_OFFSET )
    ) u_bank2 (
        .clk ( clk ), .rst ( rst ),
        .slot0_cs ( LVBL ), .slot0_addr ( char_addr ),
        .slot0_ok ( char_ok ), .slot0_dout ( char_data ),
        .slot1_cs ( LVBL ), .slot1_addr ( scr1_addr ),
        .slot1_ok ( scr1_ok ), .slot1_dout ( scr1_data ),
        .bank_req ( bank_req[2] ), .bank_addr ( bank_addr[2] ),
        .bank_ack ( bank_ack[2] ), .bank_rdy ( bank_rdy[2] ), .data_read ( data_read )
    );

    // Bank 3: scroll 2 and objects, objects also fetch in blank
    rom_bank_port #(
        .SLOT1_EN ( 1'b1 ),
        .AW0 ( SCR2_AW ), .DW0 ( 16 ), .OFFSET0 ( ZERO_OFFSET ),
        .AW1 ( OBJ_AW ),  .DW1 ( 16 ), .OFFSET1 ( OBJ_OFFSET )
    ) u_bank3 (
        .clk ( clk ), .rst ( rst ),
        .slot0_cs ( LVBL ), .slot0_addr ( scr2_addr ),
        .slot0_ok ( scr2_ok ), .slot0_dout ( scr2_data ),
        .slot1_cs ( 1'b1 ), .slot1_addr ( obj_addr ),
        .slot1_ok ( obj_ok ), .slot1_dout ( obj_data ),
        .bank_req ( bank_req[3] ), .bank_addr ( bank_addr[3] ),
        .bank_ack ( bank_ack[3] ), .bank_rdy ( bank_rdy[3] ), .data_read ( data_read )
    );

    sdram_bank_sched u_sched (
        .clk        ( clk          ),
        .rst        ( rst          ),
        .refresh_en ( refresh_en   ),
        .bank_req   ( bank_req     ),
        .bank_addr0 ( bank_addr[0] ),
        .bank_addr1 ( bank_addr[1] ),
        .bank_addr2 ( bank_addr[2] ),
        .bank_addr3 ( bank_addr[3] ),
        .bank_ack   ( bank_ack     ),
        .bank_rdy   ( bank_rdy     ),
        .data_read  ( data_read    ),
        .sdram_cmd  ( sdram_cmd    ),
        .sdram_bank ( sdram_bank   ),
        .sdram_addr ( sdram_addr   ),
        .sdram_ack  ( sdram_ack    ),
        .sdram_rdy  ( sdram_rdy    ),
        .sdram_data ( sdram_data   )
    );

endmodule

`default_nettype wire

// ==== sim/tb_sdram_model.sv ====
// Behavioral SDRAM read port with variable ack and data latency, plus command counters
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_model (
    input  logic                               clk,
    input  logic                               rst,
    input  int                                 latency,
    input  rom_sdram_pkg::sdram_cmd_t          sdram_cmd,
    input  rom_sdram_pkg::bank_t               sdram_bank,
    input  logic [rom_sdram_pkg::SDRAM_AW-1:0] sdram_addr,
    output logic                               sdram_ack = 1'b0,
    output logic                               sdram_rdy = 1'b0,
    output logic [rom_sdram_pkg::SDRAM_DW-1:0] sdram_data = '0,
    output int                                 read_count,
    output int                                 refresh_count,
    output int                                 overlap_count
);
    import rom_sdram_pkg::*;

    typedef enum logic [1:0] {
        M_IDLE,
        M_ACK,
        M_DATA
    } phase_t;

    phase_t              phase;
    int                  cnt;
    sdram_cmd_t          cur_cmd;
    bank_t               cur_bank;
    logic [SDRAM_AW-1:0] cur_addr;

    // Memory contents: bank in the top bits, then address bits
    function automatic logic [SDRAM_DW-1:0] model_word(input logic [1:0] bank,
                                                        input logic [SDRAM_AW-1:0] a);
        return {bank, a[21:8], a[15:0]};
    endfunction

    // Outputs change on the falling edge, the DUT samples them on the rising edge
    always @(negedge clk) begin
        sdram_ack <= 1'b0;
        sdram_rdy <= 1'b0;
        if (rst) begin
            phase         <= M_IDLE;
            cnt           <= 0;
            read_count    <= 0;
            refresh_count <= 0;
            overlap_count <= 0;
        end else begin
            case (phase)
                M_IDLE: begin
                    if (sdram_cmd != CMD_NOP) begin
                        cur_cmd  <= sdram_cmd;
                        cur_bank <= sdram_bank;
                        cur_addr <= sdram_addr;
                        cnt      <= latency;
                        phase    <= M_ACK;
                    end
                end
                M_ACK: begin
                    if (cnt <= 1) begin
                        sdram_ack <= 1'b1;
                        if (cur_cmd == CMD_READ) begin
                            read_count <= read_count + 1;
                            cnt        <= latency;
                            phase      <= M_DATA;
                        end else begin
                            refresh_count <= refresh_count + 1;
                            phase         <= M_IDLE;
                        end
                    end else begin
                        cnt <= cnt - 1;
                    end
                end
                default: begin
                    // A new command while a read is open means two in flight
                    if (sdram_cmd != CMD_NOP) begin
                        overlap_count <= overlap_count + 1;
                    end
                    if (cnt <= 1) begin
                        sdram_rdy  <= 1'b1;
                        sdram_data <= model_word(cur_bank, cur_addr);
                        phase      <= M_IDLE;
                    end else begin
                        cnt <= cnt - 1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_game_sdram.sv ====
// Testbench for game_sdram: clock, reset, LFSR, reference data, client drivers and checks
`timescale 1ns/1ps
`default_nettype none

module tb_game_sdram;
    import rom_sdram_pkg::*;

    localparam int MAIN_AW = 17;
    localparam int SND_AW = 15;
    localparam int CHAR_AW = 13;
    localparam int SCR1_AW = 17;
    localparam int SCR2_AW = 15;
    localparam int OBJ_AW = 17;
    localparam logic [21:0] REGION2 = 22'h10_0000;
    localparam int OK_TIMEOUT = 300;

    // Client numbers, also bit positions in ok_vec
    localparam int C_MAIN = 0;
    localparam int C_SND = 1;
    localparam int C_CHAR = 2;
    localparam int C_SCR1 = 3;
    localparam int C_SCR2 = 4;
    localparam int C_OBJ = 5;

    logic clk = 1'b0;
    logic rst;
    logic lvbl;
    logic main_cs;
    logic snd_cs;
    logic [MAIN_AW-1:0] main_addr;
    logic [SND_AW-1:0] snd_addr;
    logic [CHAR_AW-1:0] char_addr;
    logic [SCR1_AW-1:0] scr1_addr;
    logic [SCR2_AW-1:0] scr2_addr;
    logic [OBJ_AW-1:0] obj_addr;
    logic main_ok;
    logic snd_ok;
    logic char_ok;
    logic scr1_ok;
    logic scr2_ok;
    logic obj_ok;
    logic [15:0] main_data;
    logic [7:0] snd_data;
    logic [15:0] char_data;
    logic [15:0] scr1_data;
    logic [15:0] scr2_data;
    logic [15:0] obj_data;
    sdram_cmd_t sdram_cmd;
    bank_t sdram_bank;
    logic [SDRAM_AW-1:0] sdram_addr;
    logic sdram_ack;
    logic sdram_rdy;
    logic [SDRAM_DW-1:0] sdram_data;
    logic refresh_en;
    logic [5:0] ok_vec;
    int lat;
    int read_count;
    int refresh_count;
    int overlap_count;
    logic [31:0] lfsr_q = 32'h2dfe;
    int checks = 0;
    int value_errors = 0;
    int other_errors = 0;

    assign ok_vec = {obj_ok, scr2_ok, scr1_ok, char_ok, snd_ok, main_ok};

    always #50 clk = ~clk;

    game_sdram #(
        .MAIN_AW ( MAIN_AW ), .SND_AW ( SND_AW ), .CHAR_AW ( CHAR_AW ),
        .SCR1_AW ( SCR1_AW ), .SCR2_AW ( SCR2_AW ), .OBJ_AW ( OBJ_AW )
    ) u_dut (
        .clk ( clk ), .rst ( rst ), .LVBL ( lvbl ),
        .main_cs ( main_cs ), .snd_cs ( snd_cs ),
        .main_ok ( main_ok ), .snd_ok ( snd_ok ), .char_ok ( char_ok ),
        .scr1_ok ( scr1_ok ), .scr2_ok ( scr2_ok ), .obj_ok ( obj_ok ),
        .main_addr ( main_addr ), .snd_addr ( snd_addr ), .char_addr ( char_addr ),
        .scr1_addr ( scr1_addr ), .scr2_addr ( scr2_addr ), .obj_addr ( obj_addr ),
        .main_data ( main_data ), .snd_data ( snd_data ), .char_data ( char_data ),
        .scr1_data ( scr1_data ), .scr2_data ( scr2_data ), .obj_data ( obj_data ),
        .sdram_cmd ( sdram_cmd ), .sdram_bank ( sdram_bank ), .sdram_addr ( sdram_addr ),
        .sdram_ack ( sdram_ack ), .sdram_rdy ( sdram_rdy ), .sdram_data ( sdram_data ),
        .refresh_en ( refresh_en )
    );

    tb_sdram_model u_sdram (
        .clk ( clk ), .rst ( rst ), .latency ( lat ),
        .sdram_cmd ( sdram_cmd ), .sdram_bank ( sdram_bank ), .sdram_addr ( sdram_addr ),
        .sdram_ack ( sdram_ack ), .sdram_rdy ( sdram_rdy ), .sdram_data ( sdram_data ),
        .read_count ( read_count ), .refresh_count ( refresh_count ),
        .overlap_count ( overlap_count )
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = next_lfsr(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic int pick_latency();
        return 1 + int'(rand_bits(3) % 6);
    endfunction

    // Expected client data: word address, SDRAM word rule, then lane select
    function automatic logic [15:0] ref_data(input int client, input logic [21:0] addr);
        logic [21:0] wa;
        logic [1:0] bank;
        logic [31:0] word;
        bank = 2'd3;
        wa = REGION2 + (addr >> 1);
        case (client)
            C_MAIN: begin
                bank = 2'd0;
                wa = addr >> 1;
            end
            C_SND: begin
                bank = 2'd1;
                wa = addr >> 2;
            end
            C_CHAR: begin
                bank = 2'd2;
                wa = addr >> 1;
            end
            C_SCR1: bank = 2'd2;
            C_SCR2: wa = addr >> 1;
            default: ;
        endcase
        word = {bank, wa[21:8], wa[15:0]};
        if (client == C_SND) begin
            return {8'h00, word[addr[1:0]*8 +: 8]};
        end
        return addr[0] ? word[31:16] : word[15:0];
    endfunction

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_cmd(input string name, input sdram_cmd_t exp, input sdram_cmd_t act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %0t %s expected %s got %s", $time, name, exp.name(), act.name());
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // Waits until every client in mask shows ok, optionally changing model latency
    task automatic wait_ok(input logic [5:0] mask, input bit vary_lat);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            if (vary_lat) begin
                lat <= pick_latency();
            end
            n++;
        end while ((ok_vec & mask) != mask && n < OK_TIMEOUT);
        if ((ok_vec & mask) != mask) begin
            other_errors++;
            $display("Error at %0t: timed out waiting for ok, clients %b", $time, mask);
        end
    endtask

    // Compares every ok seen high against the reference data
    always @(negedge clk) begin : compare
        logic [15:0] exp_snd;
        if (!rst) begin
            exp_snd = ref_data(C_SND, 22'(snd_addr));
            if (main_ok) check_word("main_data", ref_data(C_MAIN, 22'(main_addr)), main_data);
            if (snd_ok) check_byte("snd_data", exp_snd[7:0], snd_data);
            if (char_ok) check_word("char_data", ref_data(C_CHAR, 22'(char_addr)), char_data);
            if (scr1_ok) check_word("scr1_data", ref_data(C_SCR1, 22'(scr1_addr)), scr1_data);
            if (scr2_ok) check_word("scr2_data", ref_data(C_SCR2, 22'(scr2_addr)), scr2_data);
            if (obj_ok) check_word("obj_data", ref_data(C_OBJ, 22'(obj_addr)), obj_data);
        end
    end

    initial begin : stimulus
        logic [SND_AW-1:0] base;
        int ref_start;
        rst = 1'b1;
        lvbl = 1'b1;
        main_cs = 1'b0;
        snd_cs = 1'b0;
        main_addr = '0;
        snd_addr = '0;
        char_addr = '0;
        scr1_addr = '0;
        scr2_addr = '0;
        obj_addr = '0;
        lat = 3;

        // Quiet outputs through reset and the first cycle after it
        repeat (8) begin
            @(negedge clk);
            check_cmd("sdram_cmd", CMD_NOP, sdram_cmd);
            check_flag("any ok", 1'b0, |ok_vec);
            check_flag("refresh_en", 1'b0, refresh_en);
        end
        rst <= 1'b0;
        @(negedge clk);
        check_cmd("sdram_cmd", CMD_NOP, sdram_cmd);
        check_flag("any ok", 1'b0, |ok_vec);
        // Video slots fetch address 0 right away
        wait_ok(6'b111100, 1'b0);

        // Main CPU, random words and both halves
        main_cs <= 1'b1;
        repeat (8) begin
            main_addr <= MAIN_AW'(rand_bits(MAIN_AW));
            wait_ok(6'b000001, 1'b0);
            main_addr <= main_addr ^ 1'b1;
            @(negedge clk);
            check_flag("main_ok", 1'b1, main_ok);
        end

        // Sound CPU, four byte lanes of one word
        snd_cs <= 1'b1;
        base = SND_AW'(rand_bits(SND_AW - 2)) << 2;
        snd_addr <= base;
        wait_ok(6'b000010, 1'b0);
        for (int i = 1; i < 4; i++) begin
            snd_addr <= base | SND_AW'(i);
            @(negedge clk);
            check_flag("snd_ok", 1'b1, snd_ok);
        end

        // Char and scroll 1 share bank 2
        char_addr <= CHAR_AW'(rand_bits(CHAR_AW));
        scr1_addr <= SCR1_AW'(rand_bits(SCR1_AW));
        wait_ok(6'b001100, 1'b0);

        // All four banks miss together
        main_addr <= main_addr ^ (MAIN_AW'(1) << (MAIN_AW - 1));
        snd_addr <= snd_addr ^ (SND_AW'(1) << (SND_AW - 1));
        char_addr <= char_addr ^ (CHAR_AW'(1) << (CHAR_AW - 1));
        scr2_addr <= SCR2_AW'(rand_bits(SCR2_AW)) | (SCR2_AW'(1) << (SCR2_AW - 1));
        wait_ok(6'b010111, 1'b1);

        // Vertical blank: video slots hold, refresh runs, objects still fetch
        lvbl <= 1'b0;
        lat <= 2;
        ref_start = refresh_count;
        char_addr <= char_addr ^ (CHAR_AW'(1) << (CHAR_AW - 1));
        scr2_addr <= scr2_addr ^ (SCR2_AW'(1) << (SCR2_AW - 1));
        repeat (24) begin
            @(negedge clk);
            check_flag("char_ok", 1'b0, char_ok);
            check_flag("scr2_ok", 1'b0, scr2_ok);
            check_flag("refresh_en", 1'b1, refresh_en);
        end
        if (refresh_count == ref_start) begin
            other_errors++;
            $display("Error at %0t: no refresh commands seen in vertical blank", $time);
        end
        obj_addr <= OBJ_AW'(rand_bits(OBJ_AW));
        wait_ok(6'b100000, 1'b0);
        lvbl <= 1'b1;
        wait_ok(6'b010100, 1'b0);

        @(negedge clk);
        if (overlap_count != 0) begin
            other_errors++;
            $display("Error: SDRAM model saw %0d commands while a read was open", overlap_count);
        end
        $display("Checks %0d, value errors %0d, other errors %0d, reads %0d, refreshes %0d",
                 checks, value_errors, other_errors, read_count, refresh_count);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== game_sdram.f ====
hw/rom_sdram_pkg.sv
hw/rom_slot.sv
hw/rom_bank_port.sv
hw/sdram_bank_sched.sv
hw/game_sdram.sv
sim/tb_sdram_model.sv
sim/tb_game_sdram.sv
